//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP := tbCamConfig
FILELIST := all.f
OBJDIR := obj_dir
PASSTEXT := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

//--- all.f
common/camConfigPkg.sv
common/i2cPkg.sv
cameraSequencer/initScriptRom.sv
cameraSequencer/cameraSequencer.sv
i2cMaster/i2cMaster.sv
hw/camConfigTop.sv
testbench/tbClockGen.sv
testbench/tbSensorModel.sv
testbench/tbCamConfig.sv

//--- cameraSequencer/cameraSequencer.sv
`timescale 1ns/100ps
`default_nettype none

module cameraSequencer #(
	parameter int delayUnitCycles = 1
) (
	input  wire logic CLK_400K,
	input  wire logic RESET_N,
	input  wire camConfigPkg::scriptEntry_t scriptEntry,
	output camConfigPkg::scriptIndex_t scriptIndex,
	output i2cPkg::i2cRequest_t i2cReq,
	output logic i2cStart,
	input  wire logic i2cBusy,
	input  wire logic i2cDone,
	input  wire i2cPkg::i2cResult_t i2cRes,
	output logic configDone,
	output logic [7:0] sensorId
);

	localparam camConfigPkg::scriptIndex_t lastIndex = 5'(camConfigPkg::scriptLength - 1);
	localparam logic [3:0] gapReload = 4'(i2cPkg::busGapCycles);

	camConfigPkg::seqState_t state;
	logic reqSent; // id transaction launched, waiting for done
	logic readAck;
	logic [3:0] gapCnt;
	logic [31:0] delayCnt;
	logic canStart;
	logic isDelay;

	assign canStart = !reqSent && !i2cBusy && (gapCnt == 4'd0);
	assign isDelay = (scriptEntry.busAddr == camConfigPkg::delayTag);
	assign configDone = (state == camConfigPkg::done);

	// request follows the state, start strobe is registered
	always_comb begin
		i2cReq.op = i2cPkg::writeByte;
		i2cReq.devAddr = camConfigPkg::sensorBusAddr[7:1];
		i2cReq.regPointer = camConfigPkg::idRegPointer;
		i2cReq.wrData = 8'h00;
		case (state)
			camConfigPkg::idPointer: i2cReq.op = i2cPkg::writePointer;
			camConfigPkg::idRead: i2cReq.op = i2cPkg::readByte;
			default: begin
				i2cReq.devAddr = scriptEntry.busAddr[7:1]; // script write
				i2cReq.regPointer = scriptEntry.regPointer;
				i2cReq.wrData = scriptEntry.regData;
			end
		endcase
	end

	always_ff @(posedge CLK_400K) begin
		if (!RESET_N) begin
			state <= camConfigPkg::idle;
			scriptIndex <= '0;
			i2cStart <= 1'b0;
			reqSent <= 1'b0;
			readAck <= 1'b0;
			gapCnt <= '0;
			delayCnt <= '0;
			sensorId <= '0;
		end else begin
			i2cStart <= 1'b0;
			if (i2cDone) begin
				gapCnt <= gapReload;
			end else if (gapCnt != 4'd0) begin
				gapCnt <= gapCnt - 4'd1;
			end
			case (state)
				camConfigPkg::idle: state <= camConfigPkg::idPointer;
				camConfigPkg::idPointer: begin
					if (canStart) begin
						i2cStart <= 1'b1;
						reqSent <= 1'b1;
					end else if (reqSent && i2cDone) begin
						reqSent <= 1'b0;
						state <= camConfigPkg::idRead;
					end
				end
				camConfigPkg::idRead: begin
					if (canStart) begin
						i2cStart <= 1'b1;
						reqSent <= 1'b1;
					end else if (reqSent && i2cDone) begin
						reqSent <= 1'b0;
						sensorId <= i2cRes.rdData;
						readAck <= i2cRes.ackOk;
						state <= camConfigPkg::idCheck;
					end
				end
				camConfigPkg::idCheck: begin
					if (readAck && (sensorId == camConfigPkg::expectedSensorId)) begin
						scriptIndex <= '0;
						state <= camConfigPkg::fetch;
					end else begin
						state <= camConfigPkg::idPointer; // retry the id check
					end
				end
				camConfigPkg::fetch: state <= camConfigPkg::issueWrite; // rom latency
				camConfigPkg::issueWrite: begin
					if (isDelay) begin
						delayCnt <= 32'(scriptEntry.regData) * 32'(delayUnitCycles);
						state <= camConfigPkg::delayCount;
					end else if (canStart) begin
						i2cStart <= 1'b1;
						state <= camConfigPkg::waitWrite;
					end
				end
				camConfigPkg::waitWrite: begin
					if (i2cDone) begin
						state <= camConfigPkg::busGap; // ack ignored here
					end
				end
				camConfigPkg::busGap: begin
					if (gapCnt == 4'd0) begin
						if (scriptIndex == lastIndex) begin
							state <= camConfigPkg::done;
						end else begin
							scriptIndex <= scriptIndex + 5'd1;
							state <= camConfigPkg::fetch;
						end
					end
				end
				camConfigPkg::delayCount: begin
					if (delayCnt == 32'd0) begin
						gapCnt <= gapReload; // gap added after the delay
						state <= camConfigPkg::busGap;
					end else begin
						delayCnt <= delayCnt - 32'd1;
					end
				end
				default: state <= camConfigPkg::done; // parked until reset
			endcase
		end
	end

endmodule

`default_nettype wire

//--- cameraSequencer/initScriptRom.sv
`timescale 1ns/100ps
`default_nettype none

module initScriptRom (
	input  wire logic CLK_400K,
	input  wire camConfigPkg::scriptIndex_t scriptIndex,
	output camConfigPkg::scriptEntry_t scriptEntry
);

	function automatic camConfigPkg::scriptEntry_t regWrite(input logic [15:0] regPtr,
			input logic [7:0] value);
		return {camConfigPkg::sensorBusAddr, regPtr, value};
	endfunction

	function automatic camConfigPkg::scriptEntry_t waitUnits(input logic [7:0] units);
		return {camConfigPkg::delayTag, 16'h0000, units};
	endfunction

	always_ff @(posedge CLK_400K) begin
		case (scriptIndex)
			5'd0: scriptEntry <= regWrite(16'h0103, 8'h01); // software reset
			5'd1: scriptEntry <= waitUnits(8'd10);
			5'd2: scriptEntry <= regWrite(16'h0100, 8'h00); // standby
			5'd3: scriptEntry <= regWrite(16'h0302, 8'd24); // pll1 multiplier
			5'd4: scriptEntry <= regWrite(16'h0303, 8'h00);
			5'd5: scriptEntry <= regWrite(16'h0304, 8'h03); // mipi divider
			5'd6: scriptEntry <= regWrite(16'h3808, 8'h03); // x size 800
			5'd7: scriptEntry <= regWrite(16'h3809, 8'h20);
			5'd8: scriptEntry <= regWrite(16'h380A, 8'h01); // y size 480
			5'd9: scriptEntry <= regWrite(16'h380B, 8'hE0);
			5'd10: scriptEntry <= regWrite(16'h5018, camConfigPkg::redGain[13:6]);
			5'd11: scriptEntry <= regWrite(16'h5019, {2'b00, camConfigPkg::redGain[5:0]});
			5'd12: scriptEntry <= regWrite(16'h501A, camConfigPkg::greenGain[13:6]);
			5'd13: scriptEntry <= regWrite(16'h501B, {2'b00, camConfigPkg::greenGain[5:0]});
			5'd14: scriptEntry <= regWrite(16'h501C, camConfigPkg::blueGain[13:6]);
			5'd15: scriptEntry <= regWrite(16'h501D, {2'b00, camConfigPkg::blueGain[5:0]});
			5'd16: scriptEntry <= waitUnits(8'd10);
			default: scriptEntry <= regWrite(16'h0100, 8'h01); // stream on
		endcase
	end

endmodule

`default_nettype wire

//--- common/camConfigPkg.sv
`default_nettype none

package camConfigPkg;

	localparam logic [7:0] sensorBusAddr = 8'h6C; // write form of the bus address
	localparam logic [15:0] idRegPointer = 16'h300B;
	localparam logic [7:0] expectedSensorId = 8'h88;
	localparam logic [7:0] delayTag = 8'hAA; // in busAddr marks a delay entry
	localparam int scriptLength = 18;

	// white-balance gains, 14 bits each
	localparam logic [13:0] redGain = 14'h44A;
	localparam logic [13:0] greenGain = 14'h4C0;
	localparam logic [13:0] blueGain = 14'h400;

	typedef struct packed {
		logic [7:0] busAddr; // or delayTag
		logic [15:0] regPointer;
		logic [7:0] regData; // delay units for a delay entry
	} scriptEntry_t;

	typedef enum logic [3:0] {
		idle,
		idPointer,
		idRead,
		idCheck,
		fetch,
		issueWrite,
		waitWrite,
		busGap,
		delayCount,
		done
	} seqState_t;

	typedef logic [4:0] scriptIndex_t;

endpackage

`default_nettype wire

//--- common/i2cPkg.sv
`default_nettype none

package i2cPkg;

	typedef enum logic [1:0] {
		writePointer, // addr + 16-bit pointer
		writeByte, // addr + pointer + data
		readByte // addr with read bit + one data byte
	} i2cOp_t;

	typedef struct packed {
		i2cOp_t op;
		logic [6:0] devAddr;
		logic [15:0] regPointer;
		logic [7:0] wrData;
	} i2cRequest_t;

	typedef struct packed {
		logic ackOk; // every sampled ack was low
		logic [7:0] rdData;
	} i2cResult_t;

	localparam int phasesPerBit = 4;
	localparam int busGapCycles = 3; // idle cycles between transactions

endpackage

`default_nettype wire

//--- hw/camConfigTop.sv
`timescale 1ns/100ps
`default_nettype none

module camConfigTop #(
	parameter int delayUnitCycles = 1
) (
	input  wire logic CLK_400K,
	input  wire logic RESET_N,
	input  wire logic sdaIn,
	output logic sdaDriveLow, // 1 pulls sda low
	output logic scl,
	output logic configDone,
	output logic [7:0] sensorId
);

	camConfigPkg::scriptEntry_t scriptEntry;
	camConfigPkg::scriptIndex_t scriptIndex;
	i2cPkg::i2cRequest_t i2cReq;
	i2cPkg::i2cResult_t i2cRes;
	logic i2cStart;
	logic i2cBusy;
	logic i2cDone;

	cameraSequencer #(
		.delayUnitCycles(delayUnitCycles)
	) u_sequencer (
		.CLK_400K(CLK_400K),
		.RESET_N(RESET_N),
		.scriptEntry(scriptEntry),
		.scriptIndex(scriptIndex),
		.i2cReq(i2cReq),
		.i2cStart(i2cStart),
		.i2cBusy(i2cBusy),
		.i2cDone(i2cDone),
		.i2cRes(i2cRes),
		.configDone(configDone),
		.sensorId(sensorId)
	);

	initScriptRom u_scriptRom (
		.CLK_400K(CLK_400K),
		.scriptIndex(scriptIndex),
		.scriptEntry(scriptEntry)
	);

	i2cMaster u_i2cMaster (
		.CLK_400K(CLK_400K),
		.RESET_N(RESET_N),
		.req(i2cReq),
		.start(i2cStart),
		.busy(i2cBusy),
		.done(i2cDone),
		.result(i2cRes),
		.sdaIn(sdaIn),
		.sdaDriveLow(sdaDriveLow),
		.scl(scl)
	);

endmodule

`default_nettype wire

//--- i2cMaster/i2cMaster.sv
`timescale 1ns/100ps
`default_nettype none

module i2cMaster (
	input  wire logic CLK_400K,
	input  wire logic RESET_N,
	input  wire i2cPkg::i2cRequest_t req,
	input  wire logic start,
	output logic busy,
	output logic done,
	output i2cPkg::i2cResult_t result,
	input  wire logic sdaIn,
	output logic sdaDriveLow,
	output logic scl
);

	typedef enum logic [1:0] {
		busIdle,
		busStart,
		busBit,
		busStop
	} busState_t;

	localparam logic [1:0] lastPhase = 2'(i2cPkg::phasesPerBit - 1);
	localparam logic [1:0] samplePhase = 2'd2; // second scl-high phase

	busState_t state;
	logic [1:0] phase;
	logic [3:0] bitCnt; // 0..7 data bits, 8 is the ack slot
	logic [1:0] byteCnt;
	logic [1:0] byteLast;
	i2cPkg::i2cOp_t op;
	logic [31:0] txShift; // msb goes out first
	logic [7:0] rxShift;
	logic ackOk;
	logic ackBit;
	logic rdByte;

	assign ackBit = (bitCnt == 4'd8);
	assign rdByte = (op == i2cPkg::readByte) && (byteCnt == 2'd1); // data byte of a read
	assign busy = (state != busIdle);
	assign result = '{ackOk: ackOk, rdData: rxShift};

	always_comb begin
		scl = 1'b1;
		sdaDriveLow = 1'b0;
		case (state)
			busStart: begin
				scl = (phase != lastPhase);
				sdaDriveLow = (phase != 2'd0); // sda falls while scl high
			end
			busBit: begin
				scl = (phase == 2'd1) || (phase == 2'd2);
				sdaDriveLow = !ackBit && !txShift[31]; // released for ack and nack
			end
			busStop: begin
				scl = (phase != 2'd0);
				sdaDriveLow = (phase < 2'd2); // sda rises while scl high
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK_400K) begin
		if (!RESET_N) begin
			state <= busIdle;
			phase <= '0;
			bitCnt <= '0;
			byteCnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				busIdle: begin
					phase <= '0;
					if (start) begin
						bitCnt <= '0;
						byteCnt <= '0;
						state <= busStart;
					end
				end
				busStart: begin
					phase <= phase + 2'd1;
					if (phase == lastPhase) begin
						state <= busBit;
					end
				end
				busBit: begin
					phase <= phase + 2'd1;
					if (phase == lastPhase) begin
						if (ackBit) begin
							bitCnt <= '0;
							byteCnt <= byteCnt + 2'd1;
							if (byteCnt == byteLast) begin
								state <= busStop;
							end
						end else begin
							bitCnt <= bitCnt + 4'd1;
						end
					end
				end
				default: begin
					phase <= phase + 2'd1;
					if (phase == lastPhase) begin
						done <= 1'b1;
						state <= busIdle;
					end
				end
			endcase
		end
	end

	// request latch and shift registers
	always_ff @(posedge CLK_400K) begin
		if ((state == busIdle) && start) begin
			op <= req.op;
			ackOk <= 1'b1;
			case (req.op)
				i2cPkg::writePointer: begin
					txShift <= {req.devAddr, 1'b0, req.regPointer, 8'hFF};
					byteLast <= 2'd2;
				end
				i2cPkg::writeByte: begin
					txShift <= {req.devAddr, 1'b0, req.regPointer, req.wrData};
					byteLast <= 2'd3;
				end
				default: begin
					txShift <= {req.devAddr, 1'b1, 24'hFFFFFF}; // ones release sda
					byteLast <= 2'd1;
				end
			endcase
		end else if (state == busBit) begin
			if (phase == samplePhase) begin
				if (ackBit && !rdByte) begin
					ackOk <= ackOk && !sdaIn;
				end else if (!ackBit && rdByte) begin
					rxShift <= {rxShift[6:0], sdaIn};
				end
			end
			if ((phase == lastPhase) && !ackBit) begin
				txShift <= {txShift[30:0], 1'b1};
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tbCamConfig.sv
`timescale 1ns/100ps
`default_nettype none

module tbCamConfig;

	localparam int delayUnit = 4;
	localparam int idRows = 3;
	localparam int scriptWrites = 16;
	localparam int idleCheckCycles = 200;
	localparam int scriptDelayUnits = 20; // two delay entries of 10
	localparam int watchdogCycles = ((idRows * 2 + scriptWrites) * 40 * 4
		+ scriptDelayUnits * delayUnit + 5 + idleCheckCycles) * 2;

	typedef struct packed {
		logic [7:0] idValue;
		logic ackEnable;
		logic expectPass; // otherwise a retry
	} idRow_t;

	typedef struct packed {
		logic [15:0] pointer;
		logic [7:0] data;
		logic [7:0] delayBefore; // delay units ahead of this write
	} writeRow_t;

	typedef struct packed {
		logic [15:0] pointer;
		logic [7:0] data;
		logic [31:0] startCycle;
		logic [31:0] endCycle;
	} logEntry_t;

	logic CLK_400K;
	logic RESET_N;
	logic sdaLine;
	logic dutDriveLow;
	logic modelDriveLow;
	logic scl;
	logic configDone;
	logic [7:0] sensorId;
	logic [7:0] idValue = 8'h00;
	logic ackEnable = 1'b0;
	logic frameStart;
	logic pointerStrobe;
	logic readStrobe;
	logic writeStrobe;
	logic [15:0] lastPointer;
	logic [23:0] writeEntry;

	idRow_t idTable [idRows];
	writeRow_t writeTable [scriptWrites];
	logEntry_t writeLog [$];
	logEntry_t newEntry;
	int mismatchCount = 0;
	int problemCount = 0;
	int cycle = 0;
	int frameCount = 0;
	int pointerCount = 0;
	int readCount = 0;
	int frameStartCycle = 0;

	assign sdaLine = !((dutDriveLow === 1'b1) || modelDriveLow); // open drain with pull-up

	tbClockGen u_clockGen (
		.CLK_400K(CLK_400K),
		.RESET_N(RESET_N)
	);

	tbSensorModel u_sensor (
		.CLK_400K(CLK_400K),
		.scl(scl),
		.sda(sdaLine),
		.idValue(idValue),
		.ackEnable(ackEnable),
		.sdaDriveLow(modelDriveLow),
		.frameStart(frameStart),
		.pointerStrobe(pointerStrobe),
		.readStrobe(readStrobe),
		.writeStrobe(writeStrobe),
		.pointer(lastPointer),
		.writeEntry(writeEntry)
	);

	camConfigTop #(
		.delayUnitCycles(delayUnit)
	) u_dut (
		.CLK_400K(CLK_400K),
		.RESET_N(RESET_N),
		.sdaIn(sdaLine),
		.sdaDriveLow(dutDriveLow),
		.scl(scl),
		.configDone(configDone),
		.sensorId(sensorId)
	);

	task automatic reportMismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		mismatchCount++;
		$display("[FAIL] %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name, expected, actual);
	endtask

	task automatic reportProblem(input string what);
		problemCount++;
		$display("ERROR at %0d ns: %s", $time, what);
	endtask

	task automatic fillTables();
		idTable[0] = '{8'h65, 1'b1, 1'b0}; // wrong id
		idTable[1] = '{8'h88, 1'b0, 1'b0}; // right id, no ack
		idTable[2] = '{8'h88, 1'b1, 1'b1};
		writeTable[0] = '{16'h0103, 8'h01, 8'd0}; // software reset
		writeTable[1] = '{16'h0100, 8'h00, 8'd10};
		writeTable[2] = '{16'h0302, 8'h18, 8'd0};
		writeTable[3] = '{16'h0303, 8'h00, 8'd0};
		writeTable[4] = '{16'h0304, 8'h03, 8'd0};
		writeTable[5] = '{16'h3808, 8'h03, 8'd0}; // 800 wide
		writeTable[6] = '{16'h3809, 8'h20, 8'd0};
		writeTable[7] = '{16'h380A, 8'h01, 8'd0}; // 480 high
		writeTable[8] = '{16'h380B, 8'hE0, 8'd0};
		writeTable[9] = '{16'h5018, 8'h11, 8'd0}; // red 0x44A
		writeTable[10] = '{16'h5019, 8'h0A, 8'd0};
		writeTable[11] = '{16'h501A, 8'h13, 8'd0}; // green 0x4C0
		writeTable[12] = '{16'h501B, 8'h00, 8'd0};
		writeTable[13] = '{16'h501C, 8'h10, 8'd0}; // blue 0x400
		writeTable[14] = '{16'h501D, 8'h00, 8'd0};
		writeTable[15] = '{16'h0100, 8'h01, 8'd10}; // stream on
	endtask

	// bus event log, model strobes are stable at the rising edge
	always @(posedge CLK_400K) begin
		cycle = cycle + 1;
		if (frameStart) begin
			frameCount = frameCount + 1;
			frameStartCycle = cycle;
		end
		if (pointerStrobe) begin
			pointerCount = pointerCount + 1;
		end
		if (readStrobe) begin
			readCount = readCount + 1;
		end
		if (writeStrobe) begin
			newEntry = '{writeEntry[23:8], writeEntry[7:0], frameStartCycle, cycle};
			writeLog.push_back(newEntry);
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge CLK_400K);
		$display("Watchdog expired after %0d cycles, configuration never finished", watchdogCycles);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		logic inReset;
		int readsSeen;
		int framesAtDone;
		int gap;
		fillTables();
		idValue = idTable[0].idValue;
		ackEnable = idTable[0].ackEnable;

		inReset = 1'b1;
		while (inReset) begin // reset cycles and the first one after
			@(posedge CLK_400K);
			inReset = !RESET_N;
			@(negedge CLK_400K);
			if (scl !== 1'b1) reportMismatch("scl", 32'h1, 32'(scl));
			if (dutDriveLow !== 1'b0) reportMismatch("sdaDriveLow", 32'h0, 32'(dutDriveLow));
			if (configDone !== 1'b0) reportMismatch("configDone", 32'h0, 32'(configDone));
			if (sensorId !== 8'h00) reportMismatch("sensorId", 32'h0, 32'(sensorId));
		end

		readsSeen = 0;
		for (int row = 0; row < idRows; row++) begin
			@(negedge CLK_400K);
			idValue <= idTable[row].idValue;
			ackEnable <= idTable[row].ackEnable;
			while (readCount == readsSeen) @(negedge CLK_400K);
			readsSeen++;
			if (pointerCount != readsSeen) reportProblem("id read not preceded by a pointer write");
			if (lastPointer !== 16'h300B) reportMismatch("pointer", 32'h300B, 32'(lastPointer));
			while ((pointerCount == readsSeen) && (writeLog.size() == 0)) @(negedge CLK_400K);
			if (sensorId !== idTable[row].idValue) begin
				reportMismatch("sensorId", 32'(idTable[row].idValue), 32'(sensorId));
			end
			if (idTable[row].expectPass) begin
				if (writeLog.size() == 0) reportProblem("no script write after a matching id");
				if (pointerCount != readsSeen) reportProblem("id check repeated after a match");
			end else begin
				if (writeLog.size() != 0) reportProblem("script write after a failed id check");
			end
		end

		while (configDone !== 1'b1) @(negedge CLK_400K);
		if (writeLog.size() != scriptWrites) begin
			reportMismatch("write count", 32'(scriptWrites), 32'(writeLog.size()));
		end
		for (int i = 0; (i < scriptWrites) && (i < writeLog.size()); i++) begin
			if (writeLog[i].pointer !== writeTable[i].pointer) begin
				reportMismatch($sformatf("write %0d pointer", i), 32'(writeTable[i].pointer),
					32'(writeLog[i].pointer));
			end
			if (writeLog[i].data !== writeTable[i].data) begin
				reportMismatch($sformatf("write %0d data", i), 32'(writeTable[i].data),
					32'(writeLog[i].data));
			end
			if (i > 0) begin
				gap = int'(writeLog[i].startCycle) - int'(writeLog[i - 1].endCycle);
				if (gap < int'(writeTable[i].delayBefore) * delayUnit) begin
					reportProblem($sformatf("only %0d idle cycles before write %0d", gap, i));
				end
			end
		end

		framesAtDone = frameCount;
		repeat (idleCheckCycles) begin
			@(negedge CLK_400K);
			if (configDone !== 1'b1) reportMismatch("configDone", 32'h1, 32'(configDone));
			if (scl !== 1'b1) reportMismatch("scl", 32'h1, 32'(scl));
			if (dutDriveLow !== 1'b0) reportMismatch("sdaDriveLow", 32'h0, 32'(dutDriveLow));
		end
		if (frameCount != framesAtDone) reportProblem("bus activity after configuration done");
		if (pointerCount != idRows) reportProblem("unexpected extra id pointer writes");

		$display("Closing count: %0d value mismatches, %0d other failures",
			mismatchCount, problemCount);
		if ((mismatchCount == 0) && (problemCount == 0)) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/tbClockGen.sv
`timescale 1ns/100ps
`default_nettype none

module tbClockGen #(
	parameter int halfPeriod = 20, // 40 ns period
	parameter int resetCycles = 5
) (
	output logic CLK_400K,
	output logic RESET_N
);

	initial begin
		CLK_400K = 1'b0;
		forever #(halfPeriod) CLK_400K = ~CLK_400K;
	end

	initial begin
		RESET_N = 1'b0;
		repeat (resetCycles) @(negedge CLK_400K);
		RESET_N = 1'b1; // released on a falling edge
	end

endmodule

`default_nettype wire

//--- testbench/tbSensorModel.sv
`timescale 1ns/100ps
`default_nettype none

module tbSensorModel #(
	parameter logic [7:0] busAddr = 8'h6C
) (
	input  wire logic CLK_400K,
	input  wire logic scl,
	input  wire logic sda,
	input  wire logic [7:0] idValue,
	input  wire logic ackEnable,
	output logic sdaDriveLow,
	output logic frameStart,
	output logic pointerStrobe,
	output logic readStrobe,
	output logic writeStrobe,
	output logic [15:0] pointer, // last pointer-only write
	output logic [23:0] writeEntry // {pointer, data}
);

	logic sclPrev = 1'b1;
	logic sdaPrev = 1'b1;
	logic inFrame = 1'b0;
	logic addressed = 1'b0;
	logic readMode = 1'b0;
	logic [3:0] bitCnt = '0; // rising edges seen in this byte
	logic [2:0] byteCnt = '0;
	logic [7:0] shiftIn = '0;
	logic [7:0] txByte = '0;
	logic [7:0] ptrHigh = '0;
	logic [7:0] ptrLow = '0;
	logic [7:0] wrData = '0;

	initial begin
		sdaDriveLow = 1'b0;
		frameStart = 1'b0;
		pointerStrobe = 1'b0;
		readStrobe = 1'b0;
		writeStrobe = 1'b0;
		pointer = '0;
		writeEntry = '0;
	end

	// bus sampled on the falling clock edge, between master updates
	always @(negedge CLK_400K) begin
		frameStart <= 1'b0;
		pointerStrobe <= 1'b0;
		readStrobe <= 1'b0;
		writeStrobe <= 1'b0;
		if (sclPrev && scl && sdaPrev && !sda) begin // start condition
			inFrame = 1'b1;
			addressed = 1'b0;
			bitCnt = '0;
			byteCnt = '0;
			frameStart <= 1'b1;
		end else if (inFrame && sclPrev && scl && !sdaPrev && sda) begin // stop condition
			inFrame = 1'b0;
			sdaDriveLow <= 1'b0;
			if (addressed && !readMode && (byteCnt == 3'd3)) begin
				pointer <= {ptrHigh, ptrLow};
				pointerStrobe <= 1'b1;
			end else if (addressed && !readMode && (byteCnt == 3'd4)) begin
				writeEntry <= {ptrHigh, ptrLow, wrData};
				writeStrobe <= 1'b1;
			end else if (addressed && readMode) begin
				readStrobe <= 1'b1;
			end
		end else if (inFrame && !sclPrev && scl) begin
			if (bitCnt < 4'd8) begin
				shiftIn = {shiftIn[6:0], sda};
			end
			bitCnt = bitCnt + 4'd1;
		end else if (inFrame && sclPrev && !scl) begin
			if (bitCnt == 4'd8) begin
				if (byteCnt == 3'd0) begin
					addressed = (shiftIn[7:1] == busAddr[7:1]);
					readMode = shiftIn[0];
					sdaDriveLow <= addressed && ackEnable;
				end else if (!readMode) begin
					case (byteCnt)
						3'd1: ptrHigh = shiftIn;
						3'd2: ptrLow = shiftIn;
						3'd3: wrData = shiftIn;
						default: ;
					endcase
					sdaDriveLow <= addressed && ackEnable;
				end else begin
					sdaDriveLow <= 1'b0; // master answers the data byte
				end
			end else if (bitCnt == 4'd9) begin
				bitCnt = '0;
				byteCnt = byteCnt + 3'd1;
				if (addressed && readMode && (byteCnt == 3'd1)) begin
					txByte = idValue; // data even without ack
					sdaDriveLow <= !idValue[7];
				end else begin
					sdaDriveLow <= 1'b0;
				end
			end else if ((bitCnt != 4'd0) && addressed && readMode && (byteCnt == 3'd1)) begin
				sdaDriveLow <= !txByte[3'd7 - bitCnt[2:0]];
			end
		end
		sclPrev = scl;
		sdaPrev = sda;
	end

endmodule

`default_nettype wire
